// File: bench/remap_golden.txt
// One clock cycle per line, hex. Inputs: test ar_valid ar_id m_ar_ready r_valid r_id r_last
// aw_valid aw_id m_aw_ready b_valid b_id. Expected: m_ar_valid m_ar_id s_ar_ready s_r_id
// m_aw_valid m_aw_id s_aw_ready s_b_id. A test number of zero, or the end of file, stops.
06  00 00 01  00 00 00  00 00 01  00 00  00 00 00 00  00 00 00 00
06  00 00 01  00 00 00  00 00 01  00 00  00 00 00 00  00 00 00 00
01  01 5A 01  00 00 00  00 00 01  00 00  01 00 01 00  00 00 00 00
01  01 33 01  00 00 00  00 00 01  00 00  01 01 01 00  00 00 00 00
02  01 5A 01  00 00 00  00 00 01  00 00  01 00 01 00  00 00 00 00
02  01 5A 01  00 00 00  00 00 01  00 00  01 00 01 00  00 00 00 00
02  01 5A 01  00 00 00  00 00 01  00 00  00 00 00 00  00 00 00 00
02  01 5A 01  01 00 00  00 00 01  00 00  00 00 00 5A  00 00 00 00
02  01 5A 01  01 00 01  00 00 01  00 00  00 00 00 5A  00 00 00 00
02  01 5A 01  00 00 00  00 00 01  00 00  01 00 01 00  00 00 00 00
03  01 71 01  00 00 00  00 00 01  00 00  01 02 01 00  00 00 00 00
03  01 C4 01  00 00 00  00 00 01  00 00  01 03 01 00  00 00 00 00
03  01 9E 01  00 00 00  00 00 01  00 00  00 00 00 00  00 00 00 00
03  01 9E 01  01 01 01  00 00 01  00 00  00 00 00 33  00 00 00 00
03  01 9E 01  00 00 00  00 00 01  00 00  01 01 01 00  00 00 00 00
04  00 00 01  01 01 00  00 00 01  00 00  00 00 00 9E  00 00 00 00
04  00 00 01  01 01 01  00 00 01  00 00  00 00 00 9E  00 00 00 00
04  00 00 01  01 02 01  01 A5 01  00 00  00 00 00 71  01 00 01 00
04  00 00 01  00 00 00  01 3C 01  01 00  00 00 00 00  01 01 01 A5
04  00 00 01  01 03 01  01 77 01  01 01  00 00 00 C4  01 00 01 3C
04  01 33 01  00 00 00  00 00 01  01 00  01 01 01 00  00 00 00 77
05  01 2B 00  00 00 00  00 00 01  00 00  01 02 00 00  00 00 00 00
05  01 2B 00  00 00 00  01 4D 00  00 00  01 02 00 00  01 00 00 00
05  01 2B 00  00 00 00  01 4D 00  00 00  01 02 00 00  01 00 00 00
05  01 2B 01  00 00 00  01 4D 01  00 00  01 02 01 00  01 00 01 00
05  01 2B 01  00 00 00  00 00 01  01 00  01 02 01 00  00 00 00 4D
05  01 2B 01  00 00 00  00 00 01  00 00  01 02 01 00  00 00 00 00
05  01 2B 01  00 00 00  00 00 01  00 00  00 00 00 00  00 00 00 00
05  01 2B 01  01 02 01  00 00 01  00 00  00 00 00 2B  00 00 00 00
05  01 2B 01  00 00 00  00 00 01  00 00  01 02 01 00  00 00 00 00
06  00 00 01  00 00 00  00 00 01  00 00  00 00 00 00  00 00 00 00

// File: bench/tb_axi_id_remap.sv
/*
  Testbench for the AXI ID remapper. It acts as the upstream master and the
  downstream slave, replays bench/remap_golden.txt one clock cycle per line and
  checks IDs, handshakes and payload feed-through. Run it from the project root.
*/
`timescale 1ns/1ps

module tb_axi_id_remap
  import id_remap_pkg::*;
();

  localparam int unsigned FIELDS        = 20;
  localparam int unsigned MAX_STEPS     = 64;
  localparam int unsigned RESET_CYCLES  = 16;
  localparam int unsigned DRAIN_TIMEOUT = 20;
  localparam int unsigned DRIVE_DELAY   = 2;

  // Column positions in one golden line.
  // Input levels come first, the expected outputs follow from column 12 on.
  localparam int unsigned C_TEST = 0;
  localparam int unsigned C_AR_V = 1, C_AR_ID = 2, C_AR_RDY = 3;
  localparam int unsigned C_R_V = 4, C_R_ID = 5, C_R_LAST = 6;
  localparam int unsigned C_AW_V = 7, C_AW_ID = 8, C_AW_RDY = 9;
  localparam int unsigned C_B_V = 10, C_B_ID = 11;
  localparam int unsigned X_AR_V = 12, X_AR_ID = 13, X_AR_RDY = 14, X_R_ID = 15;
  localparam int unsigned X_AW_V = 16, X_AW_ID = 17, X_AW_RDY = 18, X_B_ID = 19;

  logic                    clk = 1'b0;
  logic                    arst_n;

  // Upstream side of the DUT.
  logic                    s_ar_valid, s_ar_ready;
  logic [SLV_ID_WIDTH-1:0] s_ar_id;
  addr_t                   s_ar_addr;
  len_t                    s_ar_len;
  logic                    s_r_valid, s_r_ready, s_r_last;
  logic [SLV_ID_WIDTH-1:0] s_r_id;
  data_t                   s_r_data;
  resp_t                   s_r_resp;
  logic                    s_aw_valid, s_aw_ready;
  logic [SLV_ID_WIDTH-1:0] s_aw_id;
  addr_t                   s_aw_addr;
  logic                    s_b_valid, s_b_ready;
  logic [SLV_ID_WIDTH-1:0] s_b_id;
  resp_t                   s_b_resp;

  // Downstream side of the DUT.
  logic                    m_ar_valid, m_ar_ready;
  logic [MST_ID_WIDTH-1:0] m_ar_id;
  addr_t                   m_ar_addr;
  len_t                    m_ar_len;
  logic                    m_r_valid, m_r_ready, m_r_last;
  logic [MST_ID_WIDTH-1:0] m_r_id;
  data_t                   m_r_data;
  resp_t                   m_r_resp;
  logic                    m_aw_valid, m_aw_ready;
  logic [MST_ID_WIDTH-1:0] m_aw_id;
  addr_t                   m_aw_addr;
  logic                    m_b_valid, m_b_ready;
  logic [MST_ID_WIDTH-1:0] m_b_id;
  resp_t                   m_b_resp;

  logic [7:0]              golden_mem [FIELDS*MAX_STEPS];
  logic [31:0]             lcg_state;
  logic [31:0]             cur_test;
  int unsigned             step;
  int unsigned             check_count;
  int unsigned             error_count;

  always #20 clk = ~clk;

  axi_id_remap DUT (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .s_ar_valid_i(s_ar_valid),
    .s_ar_ready_o(s_ar_ready),
    .s_ar_id_i   (s_ar_id),
    .s_ar_addr_i (s_ar_addr),
    .s_ar_len_i  (s_ar_len),
    .s_r_valid_o (s_r_valid),
    .s_r_ready_i (s_r_ready),
    .s_r_id_o    (s_r_id),
    .s_r_data_o  (s_r_data),
    .s_r_resp_o  (s_r_resp),
    .s_r_last_o  (s_r_last),
    .s_aw_valid_i(s_aw_valid),
    .s_aw_ready_o(s_aw_ready),
    .s_aw_id_i   (s_aw_id),
    .s_aw_addr_i (s_aw_addr),
    .s_b_valid_o (s_b_valid),
    .s_b_ready_i (s_b_ready),
    .s_b_id_o    (s_b_id),
    .s_b_resp_o  (s_b_resp),
    .m_ar_valid_o(m_ar_valid),
    .m_ar_ready_i(m_ar_ready),
    .m_ar_id_o   (m_ar_id),
    .m_ar_addr_o (m_ar_addr),
    .m_ar_len_o  (m_ar_len),
    .m_r_valid_i (m_r_valid),
    .m_r_ready_o (m_r_ready),
    .m_r_id_i    (m_r_id),
    .m_r_data_i  (m_r_data),
    .m_r_resp_i  (m_r_resp),
    .m_r_last_i  (m_r_last),
    .m_aw_valid_o(m_aw_valid),
    .m_aw_ready_i(m_aw_ready),
    .m_aw_id_o   (m_aw_id),
    .m_aw_addr_o (m_aw_addr),
    .m_b_valid_i (m_b_valid),
    .m_b_ready_o (m_b_ready),
    .m_b_id_i    (m_b_id),
    .m_b_resp_i  (m_b_resp)
  );

  // Linear congruential step for the payload fields.
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One column of one golden line, zero-extended.
  function automatic logic [31:0] gold(input int unsigned st, input int unsigned col);
    return 32'(golden_mem[st*FIELDS + col]);
  endfunction

  function automatic string test_name(input logic [31:0] t);
    case (t)
      32'd1:   return "first_ids";
      32'd2:   return "id_reuse_limit";
      32'd3:   return "table_full";
      32'd4:   return "response_ids";
      32'd5:   return "backpressure";
      32'd6:   return "reset_idle";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    assert (exp == act) else begin
      error_count++;
      $display("ERROR %s step %0d %s: expected %h, actual %h",
               test_name(cur_test), step, what, exp, act);
    end
  endtask

  // Quiet bus with every ready high. The upstream side always takes responses.
  task automatic set_idle();
    s_ar_valid = 1'b0;
    s_ar_id    = '0;
    s_ar_addr  = '0;
    s_ar_len   = '0;
    s_r_ready  = 1'b1;
    s_aw_valid = 1'b0;
    s_aw_id    = '0;
    s_aw_addr  = '0;
    s_b_ready  = 1'b1;
    m_ar_ready = 1'b1;
    m_r_valid  = 1'b0;
    m_r_id     = '0;
    m_r_data   = '0;
    m_r_resp   = '0;
    m_r_last   = 1'b0;
    m_aw_ready = 1'b1;
    m_b_valid  = 1'b0;
    m_b_id     = '0;
    m_b_resp   = '0;
  endtask

  // Control levels and IDs come from the golden line, payloads from the LCG.
  task automatic drive_step(input int unsigned st);
    s_ar_valid = (gold(st, C_AR_V) != 0);
    s_ar_id    = SLV_ID_WIDTH'(gold(st, C_AR_ID));
    m_ar_ready = (gold(st, C_AR_RDY) != 0);
    m_r_valid  = (gold(st, C_R_V) != 0);
    m_r_id     = MST_ID_WIDTH'(gold(st, C_R_ID));
    m_r_last   = (gold(st, C_R_LAST) != 0);
    s_aw_valid = (gold(st, C_AW_V) != 0);
    s_aw_id    = SLV_ID_WIDTH'(gold(st, C_AW_ID));
    m_aw_ready = (gold(st, C_AW_RDY) != 0);
    m_b_valid  = (gold(st, C_B_V) != 0);
    m_b_id     = MST_ID_WIDTH'(gold(st, C_B_ID));
    lcg_state  = lcg_next(lcg_state);
    s_ar_addr  = lcg_state;
    lcg_state  = lcg_next(lcg_state);
    s_aw_addr  = lcg_state;
    lcg_state  = lcg_next(lcg_state);
    m_r_data   = lcg_state;
    s_ar_len   = lcg_state[7:0];
    m_r_resp   = lcg_state[9:8];
    m_b_resp   = lcg_state[11:10];
    // An offered response is always taken. On idle cycles the upstream
    // readies wander, which cannot pop an entry but shows on the m_ side.
    s_r_ready  = m_r_valid || lcg_state[12];
    s_b_ready  = m_b_valid || lcg_state[13];
  endtask

  // IDs are only compared while the matching valid is expected high.
  // Payloads must equal what the testbench drove on the other side.
  task automatic check_step(input int unsigned st);
    check_value("m_ar_valid", gold(st, X_AR_V), 32'(m_ar_valid));
    check_value("s_ar_ready", gold(st, X_AR_RDY), 32'(s_ar_ready));
    if (gold(st, X_AR_V) != 0) begin
      check_value("m_ar_id", gold(st, X_AR_ID), 32'(m_ar_id));
      check_value("m_ar_addr", 32'(s_ar_addr), 32'(m_ar_addr));
      check_value("m_ar_len", 32'(s_ar_len), 32'(m_ar_len));
    end
    check_value("s_r_valid", gold(st, C_R_V), 32'(s_r_valid));
    check_value("m_r_ready", 32'(s_r_ready), 32'(m_r_ready));
    if (gold(st, C_R_V) != 0) begin
      check_value("s_r_id", gold(st, X_R_ID), 32'(s_r_id));
      check_value("s_r_data", 32'(m_r_data), 32'(s_r_data));
      check_value("s_r_resp", 32'(m_r_resp), 32'(s_r_resp));
      check_value("s_r_last", gold(st, C_R_LAST), 32'(s_r_last));
    end
    check_value("m_aw_valid", gold(st, X_AW_V), 32'(m_aw_valid));
    check_value("s_aw_ready", gold(st, X_AW_RDY), 32'(s_aw_ready));
    if (gold(st, X_AW_V) != 0) begin
      check_value("m_aw_id", gold(st, X_AW_ID), 32'(m_aw_id));
      check_value("m_aw_addr", 32'(s_aw_addr), 32'(m_aw_addr));
    end
    check_value("s_b_valid", gold(st, C_B_V), 32'(s_b_valid));
    check_value("m_b_ready", 32'(s_b_ready), 32'(m_b_ready));
    if (gold(st, C_B_V) != 0) begin
      check_value("s_b_id", gold(st, X_B_ID), 32'(s_b_id));
      check_value("s_b_resp", 32'(m_b_resp), 32'(s_b_resp));
    end
  endtask

  initial begin
    int unsigned drain;
    error_count = 0;
    check_count = 0;
    cur_test    = '0;
    step        = 0;
    lcg_state   = 32'h87d6_5760;
    arst_n      = 1'b0;
    set_idle();
    for (int i = 0; i < FIELDS*MAX_STEPS; i++) begin
      golden_mem[i] = '0;
    end
    $readmemh("bench/remap_golden.txt", golden_mem);
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    // One golden line per cycle. Test number zero marks the end of the table.
    while (step < MAX_STEPS && gold(step, C_TEST) != 0) begin
      cur_test = gold(step, C_TEST);
      drive_step(step);
      @(negedge clk);
      check_step(step);
      @(posedge clk);
      #DRIVE_DELAY;
      step++;
    end
    if (step == 0) begin
      error_count++;
      $display("The golden file is missing or holds no steps");
    end

    // Let any held request leave before the run ends.
    set_idle();
    drain = 0;
    while ((m_ar_valid || m_aw_valid) && drain < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      drain++;
    end
    if (m_ar_valid || m_aw_valid) begin
      error_count++;
      $display("Timeout: a downstream request valid stayed high after the last step");
    end

    $display("Steps: %0d, checks: %0d, errors: %0d", step, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: logic/ax_remap_ctrl.sv
/*
  Request controller for one address channel (AR or AW). It decides whether a
  request may pass, picks its downstream ID from the remap table, and holds
  that ID stable while the downstream side applies back-pressure.
*/
`timescale 1ns/1ps

module ax_remap_ctrl
  import id_remap_pkg::*;
#(
  parameter int unsigned SLV_ID_WIDTH = 1,
  parameter int unsigned MAX_UNIQ_IDS = 2,
  parameter int unsigned MST_ID_WIDTH = 1
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    ax_valid_i,
  input  logic [SLV_ID_WIDTH-1:0] ax_id_i,
  input  logic                    mst_ready_i,
  output logic                    ax_ready_o,
  output logic                    mst_valid_o,
  output logic [MST_ID_WIDTH-1:0] mst_id_o,
  remap_table_if.ctrl             tbl_if
);

  localparam int unsigned IDX_WIDTH = (MAX_UNIQ_IDS > 1) ? $clog2(MAX_UNIQ_IDS) : 1;

  typedef logic [IDX_WIDTH-1:0]    idx_t;
  typedef logic [MST_ID_WIDTH-1:0] mst_id_t;

  req_state_e state_q;
  req_state_e state_d;
  idx_t       sel_idx;
  idx_t       hold_idx_q;
  logic       can_accept;

  // The upstream ID both selects the table entry and is stored on a push.
  assign tbl_if.lookup_id   = ax_id_i;
  assign tbl_if.push_inp_id = ax_id_i;
  assign tbl_if.push_idx    = sel_idx;

  // A known ID may add one more transaction unless its entry is at the
  // limit. A new ID needs a free entry.
  assign can_accept = tbl_if.exists ? !tbl_if.exists_full : !tbl_if.full;

  always_comb begin
    state_d     = state_q;
    // Reuse the entry of an ID already in flight, else take the lowest free.
    sel_idx     = tbl_if.exists ? tbl_if.exists_idx : tbl_if.free_idx;
    mst_valid_o = 1'b0;
    ax_ready_o  = 1'b0;
    tbl_if.push = 1'b0;
    unique case (state_q)
      REQ_READY: begin
        // The entry is pushed as soon as the request goes out, whether or
        // not the downstream side takes it in this cycle.
        if (ax_valid_i && can_accept) begin
          mst_valid_o = 1'b1;
          ax_ready_o  = mst_ready_i;
          tbl_if.push = 1'b1;
          if (!mst_ready_i) begin
            state_d = REQ_HOLD;
          end
        end
      end
      REQ_HOLD: begin
        // Replay the registered ID without a second push.
        // The table state has already moved on, so a fresh lookup could differ.
        sel_idx     = hold_idx_q;
        mst_valid_o = 1'b1;
        ax_ready_o  = mst_ready_i;
        if (mst_ready_i) begin
          state_d = REQ_READY;
        end
      end
      default: begin
        state_d = REQ_READY;
      end
    endcase
  end

  // Narrow downstream ID, zero-extended from the table index.
  assign mst_id_o = mst_id_t'(sel_idx);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= REQ_READY;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the selected index while ready.
  // Only the value from the cycle that enters the hold state is ever used.
  always_ff @(posedge clk_i) begin
    if (state_q == REQ_READY) begin
      hold_idx_q <= sel_idx;
    end
  end

endmodule

// File: logic/axi_id_remap.sv
/*
  AXI ID remapper for the AR/R and AW/B channels. Wide upstream IDs become
  dense downstream IDs while distinct upstream IDs stay distinct. Payloads
  pass through unchanged, and responses get their upstream ID back.
*/
`timescale 1ns/1ps

module axi_id_remap
  import id_remap_pkg::*;
#(
  parameter int unsigned SLV_ID_WIDTH    = id_remap_pkg::SLV_ID_WIDTH,
  parameter int unsigned MAX_UNIQ_IDS    = id_remap_pkg::MAX_UNIQ_IDS,
  parameter int unsigned MAX_TXNS_PER_ID = id_remap_pkg::MAX_TXNS_PER_ID,
  parameter int unsigned MST_ID_WIDTH    = id_remap_pkg::MST_ID_WIDTH
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,

  // Upstream read address.
  input  logic                    s_ar_valid_i,
  output logic                    s_ar_ready_o,
  input  logic [SLV_ID_WIDTH-1:0] s_ar_id_i,
  input  addr_t                   s_ar_addr_i,
  input  len_t                    s_ar_len_i,

  // Upstream read data.
  output logic                    s_r_valid_o,
  input  logic                    s_r_ready_i,
  output logic [SLV_ID_WIDTH-1:0] s_r_id_o,
  output data_t                   s_r_data_o,
  output resp_t                   s_r_resp_o,
  output logic                    s_r_last_o,

  // Upstream write address.
  input  logic                    s_aw_valid_i,
  output logic                    s_aw_ready_o,
  input  logic [SLV_ID_WIDTH-1:0] s_aw_id_i,
  input  addr_t                   s_aw_addr_i,

  // Upstream write response.
  output logic                    s_b_valid_o,
  input  logic                    s_b_ready_i,
  output logic [SLV_ID_WIDTH-1:0] s_b_id_o,
  output resp_t                   s_b_resp_o,

  // Downstream read address.
  output logic                    m_ar_valid_o,
  input  logic                    m_ar_ready_i,
  output logic [MST_ID_WIDTH-1:0] m_ar_id_o,
  output addr_t                   m_ar_addr_o,
  output len_t                    m_ar_len_o,

  // Downstream read data.
  input  logic                    m_r_valid_i,
  output logic                    m_r_ready_o,
  input  logic [MST_ID_WIDTH-1:0] m_r_id_i,
  input  data_t                   m_r_data_i,
  input  resp_t                   m_r_resp_i,
  input  logic                    m_r_last_i,

  // Downstream write address.
  output logic                    m_aw_valid_o,
  input  logic                    m_aw_ready_i,
  output logic [MST_ID_WIDTH-1:0] m_aw_id_o,
  output addr_t                   m_aw_addr_o,

  // Downstream write response.
  input  logic                    m_b_valid_i,
  output logic                    m_b_ready_o,
  input  logic [MST_ID_WIDTH-1:0] m_b_id_i,
  input  resp_t                   m_b_resp_i
);

  localparam int unsigned IDX_WIDTH = (MAX_UNIQ_IDS > 1) ? $clog2(MAX_UNIQ_IDS) : 1;

  remap_table_if #(.SLV_ID_WIDTH(SLV_ID_WIDTH), .MAX_UNIQ_IDS(MAX_UNIQ_IDS)) rd_tbl_if ();
  remap_table_if #(.SLV_ID_WIDTH(SLV_ID_WIDTH), .MAX_UNIQ_IDS(MAX_UNIQ_IDS)) wr_tbl_if ();

  // Payload feed-through.
  assign m_ar_addr_o = s_ar_addr_i;
  assign m_ar_len_o  = s_ar_len_i;
  assign m_aw_addr_o = s_aw_addr_i;

  assign s_r_valid_o = m_r_valid_i;
  assign m_r_ready_o = s_r_ready_i;
  assign s_r_data_o  = m_r_data_i;
  assign s_r_resp_o  = m_r_resp_i;
  assign s_r_last_o  = m_r_last_i;

  assign s_b_valid_o = m_b_valid_i;
  assign m_b_ready_o = s_b_ready_i;
  assign s_b_resp_o  = m_b_resp_i;

  // Read direction.
  // A read transaction ends with its last R beat, so only that beat frees
  // a count. The upper ID bits are zero by construction and are not needed.
  assign rd_tbl_if.pop     = m_r_valid_i && s_r_ready_i && m_r_last_i;
  assign rd_tbl_if.pop_idx = m_r_id_i[IDX_WIDTH-1:0];
  assign s_r_id_o          = rd_tbl_if.pop_inp_id;

  id_remap_table #(
    .SLV_ID_WIDTH   (SLV_ID_WIDTH),
    .MAX_UNIQ_IDS   (MAX_UNIQ_IDS),
    .MAX_TXNS_PER_ID(MAX_TXNS_PER_ID)
  ) u_rd_table (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .tbl_if  (rd_tbl_if)
  );

  ax_remap_ctrl #(
    .SLV_ID_WIDTH(SLV_ID_WIDTH),
    .MAX_UNIQ_IDS(MAX_UNIQ_IDS),
    .MST_ID_WIDTH(MST_ID_WIDTH)
  ) u_ar_ctrl (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .ax_valid_i (s_ar_valid_i),
    .ax_id_i    (s_ar_id_i),
    .mst_ready_i(m_ar_ready_i),
    .ax_ready_o (s_ar_ready_o),
    .mst_valid_o(m_ar_valid_o),
    .mst_id_o   (m_ar_id_o),
    .tbl_if     (rd_tbl_if)
  );

  // Write direction.
  // Each B handshake closes one write transaction.
  assign wr_tbl_if.pop     = m_b_valid_i && s_b_ready_i;
  assign wr_tbl_if.pop_idx = m_b_id_i[IDX_WIDTH-1:0];
  assign s_b_id_o          = wr_tbl_if.pop_inp_id;

  id_remap_table #(
    .SLV_ID_WIDTH   (SLV_ID_WIDTH),
    .MAX_UNIQ_IDS   (MAX_UNIQ_IDS),
    .MAX_TXNS_PER_ID(MAX_TXNS_PER_ID)
  ) u_wr_table (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .tbl_if  (wr_tbl_if)
  );

  ax_remap_ctrl #(
    .SLV_ID_WIDTH(SLV_ID_WIDTH),
    .MAX_UNIQ_IDS(MAX_UNIQ_IDS),
    .MST_ID_WIDTH(MST_ID_WIDTH)
  ) u_aw_ctrl (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .ax_valid_i (s_aw_valid_i),
    .ax_id_i    (s_aw_id_i),
    .mst_ready_i(m_aw_ready_i),
    .ax_ready_o (s_aw_ready_o),
    .mst_valid_o(m_aw_valid_o),
    .mst_id_o   (m_aw_id_o),
    .tbl_if     (wr_tbl_if)
  );

endmodule

// File: logic/id_remap_pkg.sv
/*
  Shared defaults, payload types and the request controller states for the
  AXI ID remapper. Modules import it by wildcard and take what they need.
*/
package id_remap_pkg;

  // Width of the wide, sparsely used IDs on the upstream (slave) side.
  localparam int unsigned SLV_ID_WIDTH = 8;

  // Number of remap table entries per direction.
  // This is also the number of distinct downstream IDs in use.
  localparam int unsigned MAX_UNIQ_IDS = 4;

  // Transactions that may be in flight on one table entry at a time.
  localparam int unsigned MAX_TXNS_PER_ID = 3;

  // Width of the narrow downstream IDs.
  // It must cover the table index, and the upper bits are driven as zero.
  localparam int unsigned MST_ID_WIDTH = 3;

  // Address of an AR or AW request.
  typedef logic [31:0] addr_t;

  // Burst length of a read request, as beats minus one.
  typedef logic [7:0] len_t;

  // One beat of read data.
  typedef logic [31:0] data_t;

  // Response code on R and B.
  typedef logic [1:0] resp_t;

  // States of the address channel controller.
  // REQ_READY takes new requests, and REQ_HOLD replays a request that the
  // downstream side has not yet taken.
  typedef enum logic {
    REQ_READY,
    REQ_HOLD
  } req_state_e;

endpackage

// File: logic/id_remap_table.sv
/*
  Remap table for one direction, indexed by downstream ID. Each entry holds
  the upstream ID and the number of its transactions in flight. Lookups are
  combinational, and push and pop take effect at the next clock edge.
*/
`timescale 1ns/1ps

module id_remap_table #(
  parameter int unsigned SLV_ID_WIDTH    = 1,
  parameter int unsigned MAX_UNIQ_IDS    = 2,
  parameter int unsigned MAX_TXNS_PER_ID = 1
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  remap_table_if.tbl        tbl_if
);

  localparam int unsigned IDX_WIDTH = (MAX_UNIQ_IDS > 1) ? $clog2(MAX_UNIQ_IDS) : 1;
  // The counter has to reach MAX_TXNS_PER_ID itself.
  localparam int unsigned CNT_WIDTH = $clog2(MAX_TXNS_PER_ID + 1);

  typedef logic [SLV_ID_WIDTH-1:0] inp_id_t;
  typedef logic [IDX_WIDTH-1:0]    idx_t;
  typedef logic [CNT_WIDTH-1:0]    cnt_t;

  inp_id_t                 inp_id_q [MAX_UNIQ_IDS];
  cnt_t                    cnt_q    [MAX_UNIQ_IDS];

  logic [MAX_UNIQ_IDS-1:0] free_vec;
  logic [MAX_UNIQ_IDS-1:0] match_vec;
  logic [MAX_UNIQ_IDS-1:0] inc_vec;
  logic [MAX_UNIQ_IDS-1:0] dec_vec;

  // Returns the index of the lowest set bit, or zero when no bit is set.
  // Scanning downward lets the lowest hit overwrite all higher ones.
  function automatic idx_t lowest_set(input logic [MAX_UNIQ_IDS-1:0] vec);
    idx_t idx;
    idx = '0;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = idx_t'(i);
      end
    end
    return idx;
  endfunction

  // Per-entry flags.
  // An entry is free when nothing is in flight on it. An entry matches only
  // while it is in use, so a stale upstream ID in a drained entry is ignored.
  always_comb begin
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      free_vec[i]  = (cnt_q[i] == '0);
      match_vec[i] = (cnt_q[i] != '0) && (inp_id_q[i] == tbl_if.lookup_id);
      inc_vec[i]   = tbl_if.push && (tbl_if.push_idx == idx_t'(i));
      dec_vec[i]   = tbl_if.pop && (tbl_if.pop_idx == idx_t'(i));
    end
  end

  // The controller always receives the lowest free downstream ID.
  assign tbl_if.free_idx = lowest_set(free_vec);
  assign tbl_if.full     = ~|free_vec;

  // Upstream IDs are unique in the table, so at most one entry matches.
  assign tbl_if.exists_idx  = lowest_set(match_vec);
  assign tbl_if.exists      = |match_vec;
  assign tbl_if.exists_full = (cnt_q[tbl_if.exists_idx] == cnt_t'(MAX_TXNS_PER_ID));

  // Response translation back to the upstream ID.
  assign tbl_if.pop_inp_id = inp_id_q[tbl_if.pop_idx];

  // In-flight counters.
  // A push and a pop on the same entry in one cycle cancel out.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
        if (inc_vec[i] && !dec_vec[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end else if (dec_vec[i] && !inc_vec[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
      end
    end
  end

  // Upstream ID store.
  // A push to an entry in use writes the same ID again, which is harmless.
  always_ff @(posedge clk_i) begin
    if (tbl_if.push) begin
      inp_id_q[tbl_if.push_idx] <= tbl_if.push_inp_id;
    end
  end

endmodule

// File: logic/remap_table_if.sv
/*
  Signals between one remap table and the logic around it. The table modport
  serves the table itself, the ctrl modport the address channel controller.
  The top level drives the pop side directly from the response handshakes.
*/
`timescale 1ns/1ps

interface remap_table_if #(
  parameter int unsigned SLV_ID_WIDTH = 1,
  parameter int unsigned MAX_UNIQ_IDS = 2
);

  // A table with a single entry still gets a one bit index.
  localparam int unsigned IDX_WIDTH = (MAX_UNIQ_IDS > 1) ? $clog2(MAX_UNIQ_IDS) : 1;

  typedef logic [SLV_ID_WIDTH-1:0] inp_id_t;
  typedef logic [IDX_WIDTH-1:0]    idx_t;

  // Table status, combinational from the table state.
  logic    full;
  idx_t    free_idx;
  logic    exists;
  idx_t    exists_idx;
  logic    exists_full;

  // Lookup and push side, owned by the controller.
  inp_id_t lookup_id;
  logic    push;
  inp_id_t push_inp_id;
  idx_t    push_idx;

  // Pop side, driven by the response path.
  // The table hands back the upstream ID stored at pop_idx.
  logic    pop;
  idx_t    pop_idx;
  inp_id_t pop_inp_id;

  modport tbl (
    input  lookup_id, push, push_inp_id, push_idx, pop, pop_idx,
    output full, free_idx, exists, exists_idx, exists_full, pop_inp_id
  );

  modport ctrl (
    input  full, free_idx, exists, exists_idx, exists_full,
    output lookup_id, push, push_inp_id, push_idx
  );

endinterface

// File: run_sim.sh
#!/bin/sh
# Builds the AXI ID remapper testbench with Verilator, runs it from the
# project root and decides pass or fail from the simulation log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axi_id_remap -f tb.f -o tb_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
grep -q "^SIMULATION PASSED$" sim.log \
  && { echo "Run passed, see sim.log"; exit 0; } \
  || { echo "Run failed, see sim.log"; exit 1; }

// File: tb.f
logic/id_remap_pkg.sv
logic/remap_table_if.sv
logic/id_remap_table.sv
logic/ax_remap_ctrl.sv
logic/axi_id_remap.sv
bench/tb_axi_id_remap.sv
